//--- riscv_lsu.sv
`timescale 1ns/1ps

module riscv_lsu (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_req,
  input  logic                           i_we,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_addr,
  input  logic [2:0]                     i_sel,     // funct3
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_wdata,
  output logic                           o_misaligned,
  output logic                           o_load_valid,
  output logic [riscv_lsu_pkg::XLEN-1:0] o_load_data
);

  riscv_lsu_req_if req_bus ();
  riscv_lsu_rsp_if rsp_bus ();

  // stage 1, alignment check and lane steering
  riscv_lsu_align u_align (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_req        (i_req),
    .i_we         (i_we),
    .i_addr       (i_addr),
    .i_sel        (i_sel),
    .i_wdata      (i_wdata),
    .o_misaligned (o_misaligned),
    .req          (req_bus.producer)
  );

  // stage 2, memory write or read
  riscv_lsu_dmem u_dmem (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .req     (req_bus.buffer),
    .rsp     (rsp_bus.buffer)
  );

  riscv_memext u_memext (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .rsp          (rsp_bus.consumer),
    .o_load_valid (o_load_valid),
    .o_load_data  (o_load_data)
  );

endmodule

//--- riscv_lsu_align.sv
`timescale 1ns/1ps

module riscv_lsu_align (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_req,
  input  logic                           i_we,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_addr,
  input  riscv_lsu_pkg::mem_sel_u        i_sel,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_wdata,
  output logic                           o_misaligned,
  riscv_lsu_req_if.producer              req
);
  import riscv_lsu_pkg::*;

  logic [2:0]      offset;
  logic            misaligned;
  logic [7:0]      strb;
  logic [XLEN-1:0] lane_data;

  assign offset = i_addr[2:0];

  // offset must be a multiple of the access size
  always_comb begin
    case (i_sel.dec.size)
      SIZE_B:  misaligned = 1'b0;
      SIZE_H:  misaligned = offset[0];
      SIZE_W:  misaligned = |offset[1:0];
      default: misaligned = |offset;
    endcase
  end

  // strobes and lane replication so the memory only has to mask
  always_comb begin
    case (i_sel.dec.size)
      SIZE_B: begin
        strb      = 8'h01 << offset;
        lane_data = {8{i_wdata[7:0]}};
      end
      SIZE_H: begin
        strb      = 8'h03 << offset;
        lane_data = {4{i_wdata[15:0]}};
      end
      SIZE_W: begin
        strb      = 8'h0f << offset;
        lane_data = {2{i_wdata[31:0]}};
      end
      default: begin
        strb      = 8'hff;
        lane_data = i_wdata;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      req.valid    <= 1'b0;
      req.wstrb    <= 8'h00;
      o_misaligned <= 1'b0;
    end else begin
      req.valid    <= i_req & ~misaligned;   // misaligned requests are dropped here
      req.wstrb    <= (i_req && i_we && !misaligned) ? strb : 8'h00;
      o_misaligned <= i_req & misaligned;
    end
  end

  // payload
  always_ff @(posedge i_clk) begin
    req.we     <= i_we;
    req.index  <= i_addr[DMEM_AW+2:3];
    req.wdata  <= lane_data;
    req.sel    <= i_sel;
    req.offset <= offset;
  end

  // a store enables exactly its own bytes and nothing else enables any
  a_wstrb_only_on_store: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (req.valid && req.we) ? ($countones(req.wstrb) == (1 << req.sel.dec.size)
                             && req.wstrb[req.offset])
                          : (req.wstrb == 8'h00)
  );

endmodule

//--- riscv_lsu_dmem.sv
`timescale 1ns/1ps

module riscv_lsu_dmem (
  input  logic            i_clk,
  input  logic            i_rst_n,
  riscv_lsu_req_if.buffer req,
  riscv_lsu_rsp_if.buffer rsp
);
  import riscv_lsu_pkg::*;

  logic [XLEN-1:0] mem [DMEM_DEPTH];

  // byte-wise write under the strobes
  always_ff @(posedge i_clk) begin
    if (req.valid && req.we) begin
      for (int b = 0; b < 8; b++) begin
        if (req.wstrb[b]) begin
          mem[req.index][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      rsp.rvalid <= 1'b0;
    end else begin
      rsp.rvalid <= req.valid & ~req.we;
    end
  end

  // word and selector only move on a load
  always_ff @(posedge i_clk) begin
    if (req.valid && !req.we) begin
      rsp.rdata  <= mem[req.index];
      rsp.sel    <= req.sel;
      rsp.offset <= req.offset;
    end
  end

  // a store without any byte enable would be lost without trace
  a_store_has_strobe: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (req.valid && req.we) |-> (req.wstrb != 8'h00)
  );

endmodule

//--- riscv_lsu_pkg.sv
package riscv_lsu_pkg;

  // data path and address width
  localparam int XLEN = 64;

  // data memory geometry, 64-bit words
  localparam int DMEM_DEPTH = 256;
  localparam int DMEM_AW    = 8;

  // access size codes, funct3[1:0]
  localparam logic [1:0] SIZE_B = 2'd0;
  localparam logic [1:0] SIZE_H = 2'd1;
  localparam logic [1:0] SIZE_W = 2'd2;
  localparam logic [1:0] SIZE_D = 2'd3;

  typedef struct packed {
    logic       is_unsigned; // funct3[2]
    logic [1:0] size;
  } mem_sel_t;

  // one funct3 word, seen raw or split into its fields
  typedef union packed {
    logic [2:0] raw;
    mem_sel_t   dec;
  } mem_sel_u;

endpackage

//--- riscv_lsu_req_if.sv
`timescale 1ns/1ps

interface riscv_lsu_req_if;
  import riscv_lsu_pkg::*;

  logic               valid;   // one-cycle strobe
  logic               we;
  logic [DMEM_AW-1:0] index;   // word address
  logic [7:0]         wstrb;
  logic [XLEN-1:0]    wdata;   // already moved into its lanes
  mem_sel_u           sel;
  logic [2:0]         offset;

  modport producer (
    output valid, we, index, wstrb, wdata, sel, offset
  );

  modport buffer (
    input valid, we, index, wstrb, wdata, sel, offset
  );

endinterface

//--- riscv_lsu_rsp_if.sv
`timescale 1ns/1ps

interface riscv_lsu_rsp_if;
  import riscv_lsu_pkg::*;

  logic            rvalid;
  logic [XLEN-1:0] rdata;   // whole memory word
  mem_sel_u        sel;
  logic [2:0]      offset;

  modport buffer (
    output rvalid, rdata, sel, offset
  );

  modport consumer (
    input rvalid, rdata, sel, offset
  );

endinterface

//--- riscv_memext.sv
`timescale 1ns/1ps

module riscv_memext (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  riscv_lsu_rsp_if.consumer              rsp,
  output logic                           o_load_valid,
  output logic [riscv_lsu_pkg::XLEN-1:0] o_load_data
);
  import riscv_lsu_pkg::*;

  logic [7:0]  byte_fld;
  logic [15:0] half_fld;
  logic [31:0] word_fld;
  logic        uns;
  logic [2:0]  off_mask;   // offset bits that must be zero for this size

  assign uns = rsp.sel.dec.is_unsigned;

  // byte by full offset, half by offset[2:1], word by offset[2]
  assign byte_fld = rsp.rdata[8*rsp.offset +: 8];
  assign half_fld = rsp.rdata[16*rsp.offset[2:1] +: 16];
  assign word_fld = rsp.rdata[32*rsp.offset[2] +: 32];

  always_comb begin
    case (rsp.sel.dec.size)
      SIZE_B: begin
        o_load_data = {{56{~uns & byte_fld[7]}}, byte_fld};   // lb / lbu
        off_mask    = 3'b000;
      end
      SIZE_H: begin
        o_load_data = {{48{~uns & half_fld[15]}}, half_fld};  // lh / lhu
        off_mask    = 3'b001;
      end
      SIZE_W: begin
        o_load_data = {{32{~uns & word_fld[31]}}, word_fld};  // lw / lwu
        off_mask    = 3'b011;
      end
      default: begin
        o_load_data = rsp.rdata;   // ld, nothing to extend
        off_mask    = 3'b111;
      end
    endcase
  end

  assign o_load_valid = rsp.rvalid;

  // aligner drops misaligned requests, so none may reach the extender
  a_rsp_aligned: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    rsp.rvalid |-> ((rsp.offset & off_mask) == 3'b000)
  );

endmodule

//--- src.f
riscv_lsu_pkg.sv
riscv_lsu_req_if.sv
riscv_lsu_rsp_if.sv
riscv_lsu_align.sv
riscv_lsu_dmem.sv
riscv_memext.sv
riscv_lsu.sv
tb_riscv_lsu.sv

//--- tb_riscv_lsu.sv
`timescale 1ns/1ps

module tb_riscv_lsu;
  import riscv_lsu_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int N_WORDS    = 16;   // small address window so accesses collide
  localparam int N_IDLE     = 10;
  localparam int N_SUBSTORE = 60;
  localparam int N_RLOAD    = 60;
  localparam int N_MISAL    = 30;
  localparam int N_MIXED    = 150;
  localparam int N_DRAIN    = 4;
  localparam int NUM_OPS    = N_IDLE + 2 * N_WORDS + N_SUBSTORE + N_WORDS + N_RLOAD
                              + N_MISAL + N_WORDS + N_MIXED + N_DRAIN;

  logic            i_clk;
  logic            i_rst_n;
  logic            i_req;
  logic            i_we;
  logic [XLEN-1:0] i_addr;
  logic [2:0]      i_sel;
  logic [XLEN-1:0] i_wdata;
  logic            o_misaligned;
  logic            o_load_valid;
  logic [XLEN-1:0] o_load_data;

  logic [7:0]      model_mem [N_WORDS*8];
  bit              written [N_WORDS*8];
  logic [XLEN-1:0] exp_data_q [$];
  int              exp_cyc_q [$];   // negedge count at which the load shows up
  int              mis_cyc_q [$];
  int              cyc;
  int              n_checked;
  integer          seed;

  riscv_lsu UUT (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_req        (i_req),
    .i_we         (i_we),
    .i_addr       (i_addr),
    .i_sel        (i_sel),
    .i_wdata      (i_wdata),
    .o_misaligned (o_misaligned),
    .o_load_valid (o_load_valid),
    .o_load_data  (o_load_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #((NUM_OPS + 20) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [XLEN-1:0] rand64();
    logic [XLEN-1:0] v;
    v[63:32] = $random(seed);
    v[31:0]  = $random(seed);
    return v;
  endfunction

  // expected load value straight from the byte model
  function automatic logic [XLEN-1:0] load_model(input int base, input logic [2:0] f3);
    logic [XLEN-1:0] v;
    int              nbytes;
    logic            sign;
    v      = '0;
    nbytes = 1 << f3[1:0];
    for (int b = 0; b < nbytes; b++) begin
      v[8*b +: 8] = model_mem[base + b];
    end
    sign = v[8*nbytes-1];
    if (!f3[2] && nbytes < 8) begin
      for (int b = nbytes; b < 8; b++) v[8*b +: 8] = {8{sign}};
    end
    return v;
  endfunction

  function automatic bit all_written(input int base, input logic [1:0] size);
    for (int b = 0; b < (1 << size); b++) begin
      if (!written[base + b]) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_outputs();
    logic [XLEN-1:0] exp;
    if (exp_cyc_q.size() > 0 && exp_cyc_q[0] == cyc) begin
      exp = exp_data_q.pop_front();
      void'(exp_cyc_q.pop_front());
      assert (o_load_valid === 1'b1)
        else fail_now($sformatf("load response missing in cycle %0d", cyc));
      assert (o_load_data === exp)
        else fail_now($sformatf("[FAIL] %0t: load data %h, expected %h",
                                $time, o_load_data, exp));
      n_checked++;
    end else begin
      assert (o_load_valid === 1'b0)
        else fail_now($sformatf("unexpected load response in cycle %0d", cyc));
    end
    if (mis_cyc_q.size() > 0 && mis_cyc_q[0] == cyc) begin
      void'(mis_cyc_q.pop_front());
      assert (o_misaligned === 1'b1)
        else fail_now($sformatf("[FAIL] %0t: o_misaligned not raised", $time));
    end else begin
      assert (o_misaligned === 1'b0)
        else fail_now($sformatf("[FAIL] %0t: o_misaligned raised with no cause", $time));
    end
  endtask

  // check the outputs and drive one request on a falling edge
  task automatic do_op(input logic req, input logic we, input logic [3:0] word,
                       input logic [2:0] off, input logic [2:0] f3,
                       input logic [XLEN-1:0] wdata);
    int base;
    int nbytes;
    @(negedge i_clk);
    cyc++;
    check_outputs();
    i_req       = req;
    i_we        = we;
    i_addr      = '0;
    i_addr[6:3] = word;
    i_addr[2:0] = off;
    i_sel       = f3;
    i_wdata     = wdata;
    base        = word * 8 + off;
    nbytes      = 1 << f3[1:0];
    if (req) begin
      if ((off & (nbytes - 1)) != 0) begin
        mis_cyc_q.push_back(cyc + 1);   // dropped before the memory
      end else if (we) begin
        for (int b = 0; b < nbytes; b++) begin
          model_mem[base + b] = wdata[8*b +: 8];
          written[base + b]   = 1'b1;
        end
      end else begin
        exp_data_q.push_back(load_model(base, f3));
        exp_cyc_q.push_back(cyc + 2);
      end
    end
  endtask

  task automatic idle_cycle();
    do_op(1'b0, 1'b0, 4'd0, 3'd0, 3'd0, '0);
  endtask

  task automatic readback_all();
    for (int w = 0; w < N_WORDS; w++) begin
      do_op(1'b1, 1'b0, w, 3'd0, 3'd3, '0);
    end
  endtask

  initial begin
    logic [1:0] size;
    logic [2:0] off;
    logic [3:0] word;
    logic       we;
    logic       uns;
    seed      = 32'h4e80;
    cyc       = 0;
    n_checked = 0;
    i_rst_n   = 1'b0;
    i_req     = 1'b0;
    i_we      = 1'b0;
    i_addr    = '0;
    i_sel     = 3'd0;
    i_wdata   = '0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    repeat (N_IDLE) idle_cycle();   // nothing may come out

    for (int w = 0; w < N_WORDS; w++) begin
      do_op(1'b1, 1'b1, w, 3'd0, 3'd3, rand64());
    end
    readback_all();

    // sb / sh / sw
    for (int i = 0; i < N_SUBSTORE; i++) begin
      size = rand_below(3);
      off  = rand_below(8) & (3'b111 << size);
      do_op(1'b1, 1'b1, rand_below(N_WORDS), off, {1'b0, size}, rand64());
    end
    readback_all();

    // lb lbu lh lhu lw lwu
    for (int i = 0; i < N_RLOAD; i++) begin
      size = rand_below(3);
      uns  = rand_below(2);
      off  = rand_below(8) & (3'b111 << size);
      word = rand_below(N_WORDS);
      we   = !all_written(word * 8 + off, size);
      do_op(1'b1, we, word, off, {uns & ~we, size}, rand64());
    end

    for (int i = 0; i < N_MISAL; i++) begin
      size = 1 + rand_below(3);
      off  = rand_below(8);
      if ((off & ((3'b001 << size) - 1)) == 0) off = off | 3'b001;
      do_op(1'b1, rand_below(2), rand_below(N_WORDS), off, {1'b0, size}, rand64());
    end
    readback_all();   // misaligned stores must not show here

    // back to back with no idle cycles
    for (int i = 0; i < N_MIXED; i++) begin
      size = rand_below(4);
      off  = rand_below(8) & (3'b111 << size);
      word = rand_below(N_WORDS);
      we   = rand_below(2);
      uns  = rand_below(2);
      if (!we && !all_written(word * 8 + off, size)) we = 1'b1;
      do_op(1'b1, we, word, off, {uns & ~we & (size != 2'd3), size}, rand64());
    end

    repeat (N_DRAIN) idle_cycle();
    $display("%0d loads checked", n_checked);
    $display("STATUS: PASS");
    $finish;
  end

endmodule
